//--- project.f
rvPkg.sv
RegisterFile.sv
StallController.sv
StageIF.sv
StageID.sv
StageEX.sv
StageMEM.sv
ProcessorPP.sv
tbClock.sv
tbProcessor.sv

//--- tbProcessor.sv
`timescale 1ns/1ns
`default_nettype none

module tbProcessor
    import rvPkg::*;
();

    localparam int STORE_TIMEOUT = 200;         // Cycles allowed per store
    localparam int IDLE_CYCLES   = 24;          // Quiet window after the last store
    localparam int MEM_WORDS     = 64;

    typedef struct packed {
        aluOpT       op;
        logic        isImm;                     // ADDI instead of a register op
        dataT        a;
        dataT        b;
        logic [11:0] imm;
        dataT        expResult;
    } rowT;

    logic        clock;
    logic        rstN;
    logic        rstReq;
    instReqT     instReq;
    instT        inst;
    dataReqT     dataReq;
    dataRspT     dataRsp;
    dataT        imem [MEM_WORDS];
    dataT        dmem [MEM_WORDS];
    logic [1:0]  waitCnt;                       // Busy cycles left for this access
    logic [31:0] rndWord;
    integer      seed;
    dataT        addrQ [$];                     // Completed stores, in order
    dataT        dataQ [$];
    rowT         rowQ [$];

    tbClock clk0 (.i_rstReq(rstReq), .o_clock(clock), .o_rstN(rstN));

    ProcessorPP dut0 (
        .i_clock   (clock),
        .i_rstN    (rstN),
        .o_instReq (instReq),
        .i_inst    (inst),
        .o_dataReq (dataReq),
        .i_dataRsp (dataRsp));

    // ------------------------------------------------------------------------
    // Memory models
    // ------------------------------------------------------------------------

    assign inst    = imem[instReq.addr[7:2]];   // Same-cycle fetch
    assign dataRsp = {dmem[dataReq.addr[7:2]],
                      (dataReq.rd || dataReq.wr) && (waitCnt != 2'd0)};

    always @(posedge clock) begin
        if (dataReq.rd || dataReq.wr) begin
            if (waitCnt != 2'd0)
                waitCnt <= waitCnt - 2'd1;      // Still busy
            else begin                          // Access completes at this edge
                if (dataReq.wr) begin
                    dmem[dataReq.addr[7:2]] <= dataReq.wrData;
                    addrQ.push_back(dataReq.addr);
                    dataQ.push_back(dataReq.wrData);
                end
                rndWord = $random(seed);
                waitCnt <= rndWord[1:0];        // 0 to 3 busy cycles next access
            end
        end
    end

    // ------------------------------------------------------------------------
    // Encoders and helpers
    // ------------------------------------------------------------------------

    function automatic logic [9:0] rFunct(aluOpT op);   // {funct7, funct3}
        case (op)
            ALU_ADD: return {7'h00, 3'b000};
            ALU_SUB: return {7'h20, 3'b000};
            ALU_AND: return {7'h00, 3'b111};
            ALU_OR:  return {7'h00, 3'b110};
            ALU_XOR: return {7'h00, 3'b100};
            ALU_SLT: return {7'h00, 3'b010};
            default: return 10'h000;
        endcase
    endfunction

    function automatic instT encR(logic [9:0] fn, regAddrT rd, regAddrT rs1, regAddrT rs2);
        return {fn[9:3], rs2, rs1, fn[2:0], rd, OPC_OP};
    endfunction

    function automatic instT encI(logic [11:0] imm, regAddrT rs1, logic [2:0] f3,
                                  regAddrT rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instT encS(logic [11:0] imm, regAddrT rs2, regAddrT rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};   // SW
    endfunction

    function automatic instT encB(logic [12:0] imm, regAddrT rs2, regAddrT rs1,
                                  logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic checkDataWord(input string name, input dataT got, input dataT exp);
        if (got !== exp)
            abortRun($sformatf("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                               $time, name, got, exp));
    endtask

    task automatic checkStoreAddr(input dataT got, input dataT exp);
        if (got !== exp)
            abortRun($sformatf("** Error at %0t ns: o_dataReq.addr = 0x%08h, expected 0x%08h",
                               $time, got, exp));
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abortRun($sformatf("** Error at %0t ns: %s = %b, expected %b",
                               $time, name, got, exp));
    endtask

    task automatic fillDataMem(input dataT a, input dataT b);
        for (int i = 0; i < MEM_WORDS; i++)
            dmem[i] = 32'hC0DE_0000 ^ (i << 2); // Pattern from the byte address
        dmem[0] = a;
        dmem[1] = b;
    endtask

    task automatic fillInstMem();
        logic [11:0] byteAddr;
        for (int i = 0; i < MEM_WORDS; i++) begin
            byteAddr = i * 4;
            imem[i]  = {byteAddr, 20'h00013};   // ADDI x0,x0,addr
        end
    endtask

    task automatic loadProgram(input rowT r);
        instT opInst;
        fillInstMem();
        if (r.isImm)
            opInst = encI(r.imm, 5'd1, 3'b000, 5'd3, OPC_OPIMM);   // ADDI x3,x1,imm
        else
            opInst = encR(rFunct(r.op), 5'd3, 5'd1, 5'd2);        // OP x3,x1,x2
        imem[0] = encI(12'd0, 5'd0, 3'b010, 5'd1, OPC_LOAD);      // LW x1,0(x0)
        imem[1] = encI(12'd4, 5'd0, 3'b010, 5'd2, OPC_LOAD);      // LW x2,4(x0)
        imem[2] = opInst;
        imem[3] = encS(12'd8, 5'd3, 5'd0);                        // SW x3,8(x0)
        imem[4] = encB(13'd8, 5'd0, 5'd3, 3'b000);                // BEQ x3,x0,+8
        imem[5] = encS(12'd12, 5'd1, 5'd0);                       // SW x1,12(x0)
        imem[6] = encB(13'd4, 5'd1, 5'd0, 3'b001);                // BNE x0,x1,+4
        imem[7] = encS(12'd16, 5'd2, 5'd0);                       // SW x2,16(x0)
        imem[8] = encB(13'd0, 5'd0, 5'd0, 3'b000);                // BEQ x0,x0,0
    endtask

    task automatic addRow(input aluOpT op, input logic isImm, input dataT a, input dataT b,
                          input logic [11:0] imm, input dataT expResult);
        rowT r;
        r.op        = op;
        r.isImm     = isImm;
        r.a         = a;
        r.b         = b;
        r.imm       = imm;
        r.expResult = expResult;
        rowQ.push_back(r);
    endtask

    task automatic waitForStores(input int n);
        int cycles;
        cycles = 0;
        while ((addrQ.size() < n) && (cycles < STORE_TIMEOUT)) begin
            @(negedge clock);
            cycles++;
        end
        if (addrQ.size() < n)
            abortRun($sformatf("Timeout at %0t ns: no store arrived, store %0d missing",
                               $time, n));
    endtask

    // ------------------------------------------------------------------------
    // One row: reset, load, run, collect stores
    // ------------------------------------------------------------------------

    task automatic runRow(input rowT r);
        dataT expAddr [3];
        dataT expData [3];
        int   expCount;
        int   cycles;
        @(posedge clock);
        rstReq <= 1'b1;
        @(negedge clock);                       // Pipeline in reset, bus idle
        addrQ.delete();
        dataQ.delete();
        fillDataMem(r.a, r.b);
        loadProgram(r);
        for (int i = 0; i < 5; i++)
            @(posedge clock);
        rstReq <= 1'b0;
        @(negedge clock);                       // No edge since release
        checkBit("o_dataReq.rd", dataReq.rd, 1'b0);
        checkBit("o_dataReq.wr", dataReq.wr, 1'b0);
        checkDataWord("o_instReq.addr", instReq.addr, RESET_PC);

        expAddr[0] = 32'd8;                     // ALU result first
        expData[0] = r.expResult;
        if (r.expResult != '0) begin            // BEQ falls through
            expAddr[1] = 32'd12;
            expData[1] = r.a;
            expAddr[2] = 32'd16;
            expData[2] = r.b;
            expCount   = 3;
        end
        else begin                              // BEQ skips the store to 12
            expAddr[1] = 32'd16;
            expData[1] = r.b;
            expCount   = 2;
        end

        for (int k = 0; k < expCount; k++) begin
            waitForStores(k + 1);
            checkStoreAddr(addrQ[k], expAddr[k]);
            checkDataWord("o_dataReq.wrData", dataQ[k], expData[k]);
        end

        cycles = 0;
        while (cycles < IDLE_CYCLES) begin      // Program spins on its last BEQ
            @(negedge clock);
            cycles++;
        end
        if (addrQ.size() != expCount)
            abortRun($sformatf("Wrong store count at %0t ns: %0d stores seen, %0d expected",
                               $time, addrQ.size(), expCount));
    endtask

    initial begin
        seed     = 32'h797c765d;
        rstReq   = 1'b1;
        waitCnt  = 2'd0;
        fillDataMem('0, '0);
        fillInstMem();

        addRow(ALU_ADD, 1'b0, 32'd5,          32'd7,          12'h000, 32'd12);
        addRow(ALU_SUB, 1'b0, 32'd5,          32'd5,          12'h000, 32'd0);
        addRow(ALU_SUB, 1'b0, 32'd3,          32'd10,         12'h000, 32'hFFFF_FFF9);
        addRow(ALU_AND, 1'b0, 32'hF0F0_1234,  32'h0FF0_FF00,  12'h000, 32'h00F0_1200);
        addRow(ALU_OR,  1'b0, 32'hF000_0001,  32'h0000_0F00,  12'h000, 32'hF000_0F01);
        addRow(ALU_XOR, 1'b0, 32'h1234_5678,  32'hFFFF_0000,  12'h000, 32'hEDCB_5678);
        addRow(ALU_SLT, 1'b0, 32'hFFFF_FFFF,  32'd1,          12'h000, 32'd1);
        addRow(ALU_SLT, 1'b0, 32'd5,          32'hFFFF_FFFD,  12'h000, 32'd0);
        addRow(ALU_ADD, 1'b1, 32'd100,        32'h1357_9BDF,  12'hF9C, 32'd0);  // Imm -100
        addRow(ALU_ADD, 1'b1, 32'h7FFF_FFF0,  32'hFFFF_FFFF,  12'h010, 32'h8000_0000);

        for (int i = 0; i < rowQ.size(); i++)
            runRow(rowQ[i]);

        $display("Finished with no errors");
        $finish;
    end

    initial begin                               // Global run limit
        #200000;
        abortRun("Run limit reached before all rows finished");
    end

endmodule

`default_nettype wire

//--- tbClock.sv
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    input  logic i_rstReq,                      // Extra reset request from the testbench
    output logic o_clock,
    output logic o_rstN);

    logic [2:0] initCycles;                     // Counts the power-on reset

    initial begin
        o_clock    = 1'b0;
        initCycles = 3'd0;
        forever #2 o_clock = ~o_clock;          // 4 ns period
    end

    always @(posedge o_clock) begin
        if (initCycles < 3'd5)
            initCycles <= initCycles + 3'd1;
    end

    assign o_rstN = (initCycles >= 3'd5) && !i_rstReq;  // Low for 5 cycles after start

endmodule

`default_nettype wire

//--- ProcessorPP.sv
`timescale 1ns/1ns
`default_nettype none

module ProcessorPP
    import rvPkg::*;
(
    input  logic    i_clock,                    // Clock
    input  logic    i_rstN,                     // Reset, active low
    output instReqT o_instReq,                  // Instruction bus
    input  instT    i_inst,
    output dataReqT o_dataReq,                  // Data bus
    input  dataRspT i_dataRsp);

    stallCtrlT stallCtrl;
    ifIdT      ifId;
    idExT      idEx;
    exMemT     exMem;
    memWbT     memWb;
    regAddrT   rdAddrA, rdAddrB;
    dataT      rdDataA, rdDataB;
    logic      regWrEnable;
    regAddrT   regWrAddr;
    dataT      regWrData;
    logic      loadUse, branchTaken;
    dataT      branchTarget;

    // ------------------------------------------------------------------------
    // Register file and hazard control
    // ------------------------------------------------------------------------

    RegisterFile
    regs (
        .i_clock    (i_clock),
        .i_rstN     (i_rstN),
        .i_rdAddrA  (rdAddrA),
        .i_rdAddrB  (rdAddrB),
        .o_rdDataA  (rdDataA),
        .o_rdDataB  (rdDataB),
        .i_wrEnable (regWrEnable),              // From MEM/WB
        .i_wrAddr   (regWrAddr),
        .i_wrData   (regWrData));

    StallController
    stallCtrl0 (
        .i_loadUse     (loadUse),
        .i_branchTaken (branchTaken),
        .i_memBusy     (i_dataRsp.busy),
        .o_stallCtrl   (stallCtrl));

    // ------------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------------

    StageIF
    stageIF (
        .i_clock        (i_clock),
        .i_rstN         (i_rstN),
        .i_stallCtrl    (stallCtrl),
        .i_branchTaken  (branchTaken),
        .i_branchTarget (branchTarget),
        .o_instReq      (o_instReq),
        .i_inst         (i_inst),
        .o_ifId         (ifId));

    StageID
    stageID (
        .i_clock        (i_clock),
        .i_rstN         (i_rstN),
        .i_stallCtrl    (stallCtrl),
        .i_ifId         (ifId),
        .o_rdAddrA      (rdAddrA),
        .o_rdAddrB      (rdAddrB),
        .i_rdDataA      (rdDataA),
        .i_rdDataB      (rdDataB),
        .i_exMem        (exMem),                // Forward from MEM
        .i_memWb        (memWb),                // Forward from WB
        .o_loadUse      (loadUse),
        .o_branchTaken  (branchTaken),
        .o_branchTarget (branchTarget),
        .o_idEx         (idEx));

    StageEX
    stageEX (
        .i_clock        (i_clock),
        .i_rstN         (i_rstN),
        .i_stallCtrl    (stallCtrl),
        .i_idEx         (idEx),
        .o_exMem        (exMem));

    StageMEM
    stageMEM (
        .i_clock        (i_clock),
        .i_rstN         (i_rstN),
        .i_stallCtrl    (stallCtrl),
        .i_exMem        (exMem),
        .o_dataReq      (o_dataReq),
        .i_dataRsp      (i_dataRsp),
        .o_memWb        (memWb),
        .o_regWrEnable  (regWrEnable),
        .o_regWrAddr    (regWrAddr),
        .o_regWrData    (regWrData));

endmodule

`default_nettype wire

//--- StageMEM.sv
`timescale 1ns/1ns
`default_nettype none

module StageMEM
    import rvPkg::*;
(
    input  logic      i_clock,                  // Clock
    input  logic      i_rstN,                   // Reset, active low
    input  stallCtrlT i_stallCtrl,
    input  exMemT     i_exMem,                  // EX/MEM register
    output dataReqT   o_dataReq,                // Data bus
    input  dataRspT   i_dataRsp,
    output memWbT     o_memWb,                  // MEM/WB register
    output logic      o_regWrEnable,            // Register file write
    output regAddrT   o_regWrAddr,
    output dataT      o_regWrData);

    wbSelT wbSel;
    dataT  wbData;

    // Request held stable by the EX/MEM stall
    always_comb begin
        o_dataReq.addr   = i_exMem.result;
        o_dataReq.wrData = i_exMem.storeData;
        o_dataReq.rd     = i_exMem.valid && i_exMem.memRd;
        o_dataReq.wr     = i_exMem.valid && i_exMem.memWr;
    end

    assign wbSel  = i_exMem.memRd ? WB_LOAD : WB_ALU;
    assign wbData = (wbSel == WB_LOAD) ? i_dataRsp.rdData : i_exMem.result;

    // ------------------------------------------------------------------------
    // MEM/WB register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            o_memWb <= '0;
        else if (i_stallCtrl.memWbFlush) begin  // Nothing completes while busy
            o_memWb.valid <= 1'b0;
            o_memWb.regWr <= 1'b0;
        end
        else begin
            o_memWb.valid     <= i_exMem.valid;
            o_memWb.regWr     <= i_exMem.regWr;
            o_memWb.regWrAddr <= i_exMem.regWrAddr;
            o_memWb.regWrData <= wbData;
        end
    end

    // Write-back
    assign o_regWrEnable = o_memWb.valid && o_memWb.regWr;
    assign o_regWrAddr   = o_memWb.regWrAddr;
    assign o_regWrData   = o_memWb.regWrData;

endmodule

`default_nettype wire

//--- StageEX.sv
`timescale 1ns/1ns
`default_nettype none

module StageEX
    import rvPkg::*;
(
    input  logic      i_clock,                  // Clock
    input  logic      i_rstN,                   // Reset, active low
    input  stallCtrlT i_stallCtrl,
    input  idExT      i_idEx,                   // ID/EX register
    output exMemT     o_exMem);                 // EX/MEM register

    dataT opB;
    dataT result;

    assign opB = i_idEx.useImm ? i_idEx.imm : i_idEx.opB;

    // ALU
    always_comb begin
        case (i_idEx.aluOp)
            ALU_ADD: result = i_idEx.opA + opB;
            ALU_SUB: result = i_idEx.opA - opB;
            ALU_AND: result = i_idEx.opA & opB;
            ALU_OR:  result = i_idEx.opA | opB;
            ALU_XOR: result = i_idEx.opA ^ opB;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, $signed(i_idEx.opA) < $signed(opB)};
            default: result = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // EX/MEM register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            o_exMem <= '0;
        else if (!i_stallCtrl.exMemStall) begin // Holds while memory busy
            o_exMem.valid     <= i_idEx.valid;
            o_exMem.result    <= result;
            o_exMem.storeData <= i_idEx.opB;    // rs2, not the immediate
            o_exMem.memRd     <= i_idEx.memRd;
            o_exMem.memWr     <= i_idEx.memWr;
            o_exMem.regWr     <= i_idEx.regWr;
            o_exMem.regWrAddr <= i_idEx.regWrAddr;
        end
    end

endmodule

`default_nettype wire

//--- StageID.sv
`timescale 1ns/1ns
`default_nettype none

module StageID
    import rvPkg::*;
(
    input  logic      i_clock,                  // Clock
    input  logic      i_rstN,                   // Reset, active low
    input  stallCtrlT i_stallCtrl,
    input  ifIdT      i_ifId,
    output regAddrT   o_rdAddrA,                // Register file reads
    output regAddrT   o_rdAddrB,
    input  dataT      i_rdDataA,
    input  dataT      i_rdDataB,
    input  exMemT     i_exMem,                  // Forwarding sources
    input  memWbT     i_memWb,
    output logic      o_loadUse,                // Operand not yet available
    output logic      o_branchTaken,
    output dataT      o_branchTarget,
    output idExT      o_idEx);                  // ID/EX register

    instT    inst;
    regAddrT rs1, rs2, rd;
    dataT    immI, immS, immB;
    dataT    fwdA, fwdB;
    idExT    dec;                               // Decoded payload
    logic    legal, isBranch, isBne;
    logic    useRs1, useRs2;
    logic    hazEx, hazMem;

    // Youngest producer first, then WB, then register file
    function automatic dataT forward(regAddrT rs, dataT rf, exMemT ex, memWbT wb);
        if (rs == '0)
            return rf;
        if (ex.valid && ex.regWr && (ex.regWrAddr == rs))
            return ex.result;
        if (wb.valid && wb.regWr && (wb.regWrAddr == rs))
            return wb.regWrData;
        return rf;
    endfunction

    assign inst = i_ifId.inst;
    assign rs1  = inst[19:15];
    assign rs2  = inst[24:20];
    assign rd   = inst[11:7];
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    assign o_rdAddrA = rs1;
    assign o_rdAddrB = rs2;
    assign fwdA      = forward(rs1, i_rdDataA, i_exMem, i_memWb);
    assign fwdB      = forward(rs2, i_rdDataB, i_exMem, i_memWb);

    // ------------------------------------------------------------------------
    // Decoder
    // ------------------------------------------------------------------------

    always_comb begin
        legal         = 1'b1;
        isBranch      = 1'b0;
        isBne         = inst[12];               // funct3 001
        useRs1        = 1'b1;
        useRs2        = 1'b0;
        dec           = '0;
        dec.aluOp     = ALU_ADD;                // Address add for LW/SW
        dec.opA       = fwdA;
        dec.opB       = fwdB;
        dec.regWrAddr = rd;
        case (inst[6:0])
            OPC_OP: begin
                useRs2    = 1'b1;
                dec.regWr = 1'b1;
                case ({inst[30], inst[14:12]})  // funct7[5], funct3
                    4'b0_000: dec.aluOp = ALU_ADD;
                    4'b1_000: dec.aluOp = ALU_SUB;
                    4'b0_111: dec.aluOp = ALU_AND;
                    4'b0_110: dec.aluOp = ALU_OR;
                    4'b0_100: dec.aluOp = ALU_XOR;
                    4'b0_010: dec.aluOp = ALU_SLT;
                    default:  legal     = 1'b0;
                endcase
            end
            OPC_OPIMM: begin                    // ADDI only
                legal      = (inst[14:12] == 3'b000);
                dec.regWr  = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immI;
            end
            OPC_LOAD: begin                     // LW only
                legal      = (inst[14:12] == 3'b010);
                dec.memRd  = 1'b1;
                dec.regWr  = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immI;
            end
            OPC_STORE: begin                    // SW only
                legal      = (inst[14:12] == 3'b010);
                useRs2     = 1'b1;
                dec.memWr  = 1'b1;
                dec.useImm = 1'b1;
                dec.imm    = immS;
            end
            OPC_BRANCH: begin                   // BEQ, BNE
                legal      = (inst[14:13] == 2'b00);
                isBranch   = 1'b1;
                useRs2     = 1'b1;
                dec.imm    = immB;
            end
            default: begin
                legal      = 1'b0;
                useRs1     = 1'b0;
            end
        endcase
        dec.valid = i_ifId.valid && legal;      // Unknown opcode is a bubble
    end

    // EX result is not forwarded to ID, so any writer in EX must stall,
    // and a load still in MEM has no data yet
    assign hazEx  = o_idEx.valid && o_idEx.regWr && (o_idEx.regWrAddr != '0) &&
                    ((useRs1 && (rs1 == o_idEx.regWrAddr)) ||
                     (useRs2 && (rs2 == o_idEx.regWrAddr)));
    assign hazMem = i_exMem.valid && i_exMem.memRd && (i_exMem.regWrAddr != '0) &&
                    ((useRs1 && (rs1 == i_exMem.regWrAddr)) ||
                     (useRs2 && (rs2 == i_exMem.regWrAddr)));
    assign o_loadUse = dec.valid && (hazEx || hazMem);

    // Branch resolves here, target from IF/ID pc
    assign o_branchTaken  = dec.valid && isBranch && ((fwdA == fwdB) ^ isBne);
    assign o_branchTarget = i_ifId.pc + immB;

    // ------------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            o_idEx <= '0;
        else if (i_stallCtrl.idExFlush)         // Bubble
            o_idEx <= '0;
        else if (!i_stallCtrl.idExStall)
            o_idEx <= dec;
    end

endmodule

`default_nettype wire

//--- StageIF.sv
`timescale 1ns/1ns
`default_nettype none

module StageIF
    import rvPkg::*;
(
    input  logic      i_clock,                  // Clock
    input  logic      i_rstN,                   // Reset, active low
    input  stallCtrlT i_stallCtrl,
    input  logic      i_branchTaken,            // Redirect from ID
    input  dataT      i_branchTarget,
    output instReqT   o_instReq,                // Instruction bus
    input  instT      i_inst,                   // Same-cycle answer
    output ifIdT      o_ifId);                  // IF/ID register

    dataT pc;

    assign o_instReq = '{addr: pc};

    // Program counter
    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            pc <= RESET_PC;
        else if (!i_stallCtrl.pcStall)
            pc <= i_branchTaken ? i_branchTarget : pc + 32'd4;
    end

    // ------------------------------------------------------------------------
    // IF/ID register
    // ------------------------------------------------------------------------

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN)
            o_ifId <= '{valid: 1'b0, pc: RESET_PC, inst: NOP_INST};
        else if (i_stallCtrl.ifIdFlush) begin   // Wrong path after branch
            o_ifId.valid <= 1'b0;
            o_ifId.inst  <= NOP_INST;
        end
        else if (!i_stallCtrl.ifIdStall) begin
            o_ifId.valid <= 1'b1;
            o_ifId.pc    <= pc;
            o_ifId.inst  <= i_inst;
        end
    end

endmodule

`default_nettype wire

//--- StallController.sv
`timescale 1ns/1ns
`default_nettype none

module StallController
    import rvPkg::*;
(
    input  logic      i_loadUse,                // Operand not ready in ID
    input  logic      i_branchTaken,            // Taken branch in ID
    input  logic      i_memBusy,                // Data bus busy
    output stallCtrlT o_stallCtrl);

    // Busy first, then load-use, then branch
    always_comb begin
        o_stallCtrl = '0;
        if (i_memBusy) begin                    // Freeze up to EX/MEM
            o_stallCtrl.pcStall    = 1'b1;
            o_stallCtrl.ifIdStall  = 1'b1;
            o_stallCtrl.idExStall  = 1'b1;
            o_stallCtrl.exMemStall = 1'b1;
            o_stallCtrl.memWbFlush = 1'b1;      // Bubble into WB
        end
        else if (i_loadUse) begin               // Hold front, bubble into EX
            o_stallCtrl.pcStall    = 1'b1;
            o_stallCtrl.ifIdStall  = 1'b1;
            o_stallCtrl.idExFlush  = 1'b1;
        end
        else if (i_branchTaken)                 // Drop the wrong-path fetch
            o_stallCtrl.ifIdFlush  = 1'b1;
    end

endmodule

`default_nettype wire

//--- RegisterFile.sv
`timescale 1ns/1ns
`default_nettype none

module RegisterFile
    import rvPkg::*;
(
    input  logic    i_clock,                    // Clock
    input  logic    i_rstN,                     // Reset, active low
    input  regAddrT i_rdAddrA,                  // Read port A
    input  regAddrT i_rdAddrB,                  // Read port B
    output dataT    o_rdDataA,
    output dataT    o_rdDataB,
    input  logic    i_wrEnable,                 // Write port
    input  regAddrT i_wrAddr,
    input  dataT    i_wrData);

    dataT regs [32];

    always_ff @(posedge i_clock or negedge i_rstN) begin
        if (!i_rstN) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_wrEnable && (i_wrAddr != '0))    // x0 never written
            regs[i_wrAddr] <= i_wrData;
    end

    // Write-through covers the WB stage
    assign o_rdDataA = (i_rdAddrA == '0) ? '0 :
                       (i_wrEnable && (i_wrAddr == i_rdAddrA)) ? i_wrData : regs[i_rdAddrA];
    assign o_rdDataB = (i_rdAddrB == '0) ? '0 :
                       (i_wrEnable && (i_wrAddr == i_rdAddrB)) ? i_wrData : regs[i_rdAddrB];

endmodule

`default_nettype wire

//--- rvPkg.sv
`default_nettype none

package rvPkg;

    // ------------------------------------------------------------------------
    // Widths and constants
    // ------------------------------------------------------------------------

    localparam int XLEN       = 32;             // Data width
    localparam int REG_ADDR_W = 5;              // Register index width

    localparam logic [31:0] NOP_INST = 32'h0000_0013;  // ADDI x0,x0,0
    localparam logic [31:0] RESET_PC = 32'h0000_0000;  // First fetch address

    localparam logic [6:0] OPC_OP     = 7'b0110011;    // Register ALU ops
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;    // ADDI
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;    // LW
    localparam logic [6:0] OPC_STORE  = 7'b0100011;    // SW
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;    // BEQ, BNE

    // ------------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------------

    typedef logic [XLEN-1:0]       dataT;
    typedef logic [REG_ADDR_W-1:0] regAddrT;
    typedef logic [31:0]           instT;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT
    } aluOpT;

    typedef enum logic {
        WB_ALU,                                 // ALU result
        WB_LOAD                                 // Data from memory
    } wbSelT;

    // ------------------------------------------------------------------------
    // Pipeline payloads
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic    valid;
        dataT    pc;
        instT    inst;
    } ifIdT;

    typedef struct packed {
        logic    valid;
        dataT    opA;                           // Forwarded rs1
        dataT    opB;                           // Forwarded rs2, store data
        dataT    imm;
        logic    useImm;                        // Imm replaces opB in the ALU
        aluOpT   aluOp;
        logic    memRd;
        logic    memWr;
        logic    regWr;
        regAddrT regWrAddr;
    } idExT;

    typedef struct packed {
        logic    valid;
        dataT    result;                        // ALU result or mem address
        dataT    storeData;
        logic    memRd;
        logic    memWr;
        logic    regWr;
        regAddrT regWrAddr;
    } exMemT;

    typedef struct packed {
        logic    valid;
        logic    regWr;
        regAddrT regWrAddr;
        dataT    regWrData;
    } memWbT;

    // ------------------------------------------------------------------------
    // Buses and control
    // ------------------------------------------------------------------------

    typedef struct packed {
        dataT    addr;                          // Fetch address
    } instReqT;

    typedef struct packed {
        dataT    addr;
        dataT    wrData;
        logic    rd;
        logic    wr;
    } dataReqT;

    typedef struct packed {
        dataT    rdData;
        logic    busy;                          // Hold request while high
    } dataRspT;

    typedef struct packed {
        logic    pcStall;
        logic    ifIdStall;
        logic    ifIdFlush;
        logic    idExStall;
        logic    idExFlush;
        logic    exMemStall;
        logic    memWbFlush;
    } stallCtrlT;

endpackage

`default_nettype wire
